/* src/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// first fetch address, kseg1 boot vector
`define MIPS_RESET_PC 32'hbfc00000

// general purpose register count
`define MIPS_NREG 32

// data word width
`define MIPS_XLEN 32

`endif

/* src/mips_pkg.sv */
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [4:0] creg_addr_t;
    typedef logic [3:0] rwen_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui,
        alu_passb
    } alu_op_e;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lb    = 6'h20,
        op_lw    = 6'h23,
        op_sb    = 6'h28,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [2:0] {
        st_fetch_req,
        st_fetch_wait,
        st_execute,
        st_mem_req,
        st_mem_wait,
        st_writeback
    } core_state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    zero_ext;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    byte_access;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    dest_rt;
    } ctrl_t;

    typedef struct packed {
        logic       req;
        word_t      addr;
        logic [1:0] size;
    } m_r_t;

    typedef struct packed {
        rwen_t wen;
        word_t addr;
        word_t wd;
    } m_w_t;

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

endpackage

/* src/alu.sv */
`timescale 1ns/1ns

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_e op,
    output mips_pkg::word_t   y,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            alu_add: begin
                y = a + b;
            end
            alu_sub: begin
                y = a - b;
            end
            alu_and: begin
                y = a & b;
            end
            alu_or: begin
                y = a | b;
            end
            // signed compare
            alu_slt: begin
                y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            alu_lui: begin
                y = {b[15:0], 16'h0000};
            end
            default: begin
                y = b;
            end
        endcase
    end

    // equal compare for beq/bne, op is sub there
    assign zero = (y == '0);

endmodule

/* src/regfile.sv */
`timescale 1ns/1ns
`include "mips_cfg.svh"

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mips_pkg::creg_addr_t ra1,
    input  mips_pkg::creg_addr_t ra2,
    output mips_pkg::word_t      rd1,
    output mips_pkg::word_t      rd2,
    input  mips_pkg::rf_w_t      w
);
    import mips_pkg::*;

    word_t regs [`MIPS_NREG];

    // r0 is never written so it stays zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MIPS_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (w.wen && (w.addr != '0)) begin
            regs[w.addr] <= w.wd;
        end
    end

    // asynchronous read
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

/* src/decoder.sv */
`timescale 1ns/1ns

module decoder (
    input  mips_pkg::word_t      instr,
    output mips_pkg::ctrl_t      ctrl,
    output mips_pkg::creg_addr_t rs,
    output mips_pkg::creg_addr_t rt,
    output mips_pkg::creg_addr_t rd,
    output mips_pkg::word_t      imm
);
    import mips_pkg::*;

    // function field of R-type instructions
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = alu_passb;
        case (opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    // unknown funct, nop
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            op_addiu, op_ori, op_lui: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.zero_ext  = (opcode != op_addiu);
                case (opcode)
                    op_addiu: ctrl.alu_op = alu_add;
                    op_ori:   ctrl.alu_op = alu_or;
                    default:  ctrl.alu_op = alu_lui;
                endcase
            end
            op_lw, op_lb: begin
                ctrl.alu_op      = alu_add;
                ctrl.use_imm     = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.dest_rt     = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.byte_access = (opcode == op_lb);
            end
            op_sw, op_sb: begin
                ctrl.alu_op      = alu_add;
                ctrl.use_imm     = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.byte_access = (opcode == op_sb);
            end
            op_beq, op_bne: begin
                ctrl.alu_op    = alu_sub;
                ctrl.branch_eq = (opcode == op_beq);
                ctrl.branch_ne = (opcode == op_bne);
            end
            op_j: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

    assign imm = ctrl.zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

/* src/datapath.sv */
`timescale 1ns/1ns
`include "mips_cfg.svh"

module datapath (
    input  logic              clk,
    input  logic              arst_n,
    output logic              inst_req,
    output mips_pkg::word_t   inst_addr,
    input  mips_pkg::word_t   inst_rdata,
    input  logic              inst_addr_ok,
    input  logic              inst_data_ok,
    output mips_pkg::m_r_t    mread,
    output mips_pkg::m_w_t    mwrite,
    input  mips_pkg::word_t   data_rdata,
    input  logic              data_addr_ok,
    input  logic              data_data_ok,
    output mips_pkg::rf_w_t   rfwrite,
    output mips_pkg::word_t   wb_pc
);
    import mips_pkg::*;

    core_state_e state;
    core_state_e state_next;
    logic        boot_done;

    word_t pc;
    word_t ipc;
    word_t ir;
    word_t alu_q;
    word_t load_q;

    ctrl_t      ctrl;
    creg_addr_t rs;
    creg_addr_t rt;
    creg_addr_t rd;
    creg_addr_t wdest;
    word_t      imm;
    word_t      rs_val;
    word_t      rt_val;
    word_t      alu_b;
    word_t      alu_y;
    logic       alu_zero;

    word_t      pc_plus4;
    word_t      br_target;
    word_t      j_target;
    word_t      pc_next;
    logic       take_branch;
    logic [7:0] load_byte;
    word_t      load_val;

    decoder decoder (.instr(ir), .ctrl, .rs, .rt, .rd, .imm);

    regfile regfile (
        .clk, .arst_n,
        .ra1(rs), .ra2(rt),
        .rd1(rs_val), .rd2(rt_val),
        .w(rfwrite)
    );

    assign alu_b = ctrl.use_imm ? imm : rt_val;

    alu alu (.a(rs_val), .b(alu_b), .op(ctrl.alu_op), .y(alu_y), .zero(alu_zero));

    // no delay slot, target is relative to pc+4
    assign pc_plus4    = pc + 32'd4;
    assign br_target   = pc_plus4 + {imm[29:0], 2'b00};
    assign j_target    = {pc_plus4[31:28], ir[25:0], 2'b00};
    assign take_branch = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

    always_comb begin
        if (ctrl.jump) begin
            pc_next = j_target;
        end else if (take_branch) begin
            pc_next = br_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_fetch_req: begin
                if (inst_req && inst_addr_ok) begin
                    state_next = st_fetch_wait;
                end
            end
            st_fetch_wait: begin
                if (inst_data_ok) begin
                    state_next = st_execute;
                end
            end
            st_execute: begin
                if (ctrl.mem_read || ctrl.mem_write) begin
                    state_next = st_mem_req;
                end else if (ctrl.reg_write) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_fetch_req;
                end
            end
            st_mem_req: begin
                if (data_addr_ok) begin
                    state_next = st_mem_wait;
                end
            end
            st_mem_wait: begin
                if (data_data_ok) begin
                    state_next = ctrl.mem_read ? st_writeback : st_fetch_req;
                end
            end
            default: begin
                state_next = st_fetch_req;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_fetch_req;
            boot_done <= 1'b0;
            pc        <= `MIPS_RESET_PC;
        end else begin
            state     <= state_next;
            boot_done <= 1'b1;
            if (state == st_execute) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch_wait && inst_data_ok) begin
            ir <= inst_rdata;
        end
        if (state == st_execute) begin
            ipc   <= pc;
            alu_q <= alu_y;
        end
        if (state == st_mem_wait && data_data_ok) begin
            load_q <= load_val;
        end
    end

    // fetch port
    assign inst_req  = boot_done && (state == st_fetch_req);
    assign inst_addr = pc;

    // lb picks the addressed byte from the word
    assign load_byte = data_rdata[{alu_q[1:0], 3'b000} +: 8];
    assign load_val  = ctrl.byte_access ? {{24{load_byte[7]}}, load_byte} : data_rdata;

    always_comb begin
        mread.req  = (state == st_mem_req) && ctrl.mem_read;
        mread.addr = alu_q;
        mread.size = ctrl.byte_access ? 2'd0 : 2'd2;
    end

    always_comb begin
        mwrite.addr = alu_q;
        mwrite.wd   = ctrl.byte_access ? {4{rt_val[7:0]}} : rt_val;
        mwrite.wen  = 4'b0000;
        if (state == st_mem_req && ctrl.mem_write) begin
            mwrite.wen = ctrl.byte_access ? (4'b0001 << alu_q[1:0]) : 4'b1111;
        end
    end

    assign wdest = ctrl.dest_rt ? rt : rd;

    always_comb begin
        rfwrite.wen  = (state == st_writeback);
        rfwrite.addr = wdest;
        rfwrite.wd   = ctrl.mem_read ? load_q : alu_q;
    end

    assign wb_pc = ipc;

endmodule

/* src/mycpu.sv */
`timescale 1ns/1ns

module mycpu (
    input  logic                 clk,
    input  logic                 arst_n,

    output logic                 inst_req,
    output mips_pkg::word_t      inst_addr,
    input  mips_pkg::word_t      inst_rdata,
    input  logic                 inst_addr_ok,
    input  logic                 inst_data_ok,

    output logic                 data_req,
    output logic                 data_wr,
    output logic [1:0]           data_size,
    output mips_pkg::word_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    input  mips_pkg::word_t      data_rdata,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,

    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);
    import mips_pkg::*;

    m_r_t  mread;
    m_w_t  mwrite;
    rf_w_t rfwrite;
    word_t inst_vaddr;

    // kseg0/kseg1 (8xxxxxxx to bxxxxxxx) drop the top three bits
    function automatic word_t phys_addr(input word_t va);
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    datapath datapath (
        .clk, .arst_n,
        .inst_req, .inst_addr(inst_vaddr), .inst_rdata, .inst_addr_ok, .inst_data_ok,
        .mread, .mwrite, .data_rdata, .data_addr_ok, .data_data_ok,
        .rfwrite, .wb_pc(debug_wb_pc)
    );

    assign inst_addr = phys_addr(inst_vaddr);

    // reads and writes share one data port and one alu address
    assign data_wr    = |mwrite.wen;
    assign data_req   = mread.req || data_wr;
    assign data_addr  = phys_addr(mread.addr);
    assign data_wdata = mwrite.wd;

    always_comb begin
        if (data_wr) begin
            data_size = (mwrite.wen == 4'b1111) ? 2'd2 : 2'd0;
        end else begin
            data_size = mread.size;
        end
    end

    // r0 writes are not reported
    assign debug_wb_rf_wen   = {4{rfwrite.wen && (rfwrite.addr != '0)}};
    assign debug_wb_rf_wnum  = rfwrite.addr;
    assign debug_wb_rf_wdata = rfwrite.wd;

endmodule

/* testbench/mycpu_assert.sv */
`timescale 1ns/1ns

module mycpu_assert (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 inst_req,
    input mips_pkg::word_t      inst_addr,
    input logic                 inst_addr_ok,
    input logic                 inst_data_ok,
    input logic                 data_req,
    input logic                 data_wr,
    input logic [1:0]           data_size,
    input mips_pkg::word_t      data_addr,
    input mips_pkg::word_t      data_wdata,
    input logic                 data_addr_ok,
    input logic                 data_data_ok,
    input mips_pkg::rwen_t      debug_wb_rf_wen
);

    logic inst_pending;
    logic data_pending;

    // count of failed properties
    int fail_count = 0;

    // one accepted request per port until its data_ok
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_pending <= 1'b0;
            data_pending <= 1'b0;
        end else begin
            if (inst_req && inst_addr_ok) begin
                inst_pending <= 1'b1;
            end else if (inst_data_ok) begin
                inst_pending <= 1'b0;
            end
            if (data_req && data_addr_ok) begin
                data_pending <= 1'b1;
            end else if (data_data_ok) begin
                data_pending <= 1'b0;
            end
        end
    end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!inst_req && !data_req && debug_wb_rf_wen == '0))
        else begin
            fail_count++;
            $error("request or writeback active during reset");
        end

    inst_held: assert property (@(posedge clk) disable iff (!arst_n)
        (inst_req && !inst_addr_ok) |=> (inst_req && $stable(inst_addr)))
        else begin
            fail_count++;
            $error("instruction request changed before acceptance");
        end

    data_held: assert property (@(posedge clk) disable iff (!arst_n)
        (data_req && !data_addr_ok) |=>
        (data_req && $stable({data_wr, data_size, data_addr, data_wdata})))
        else begin
            fail_count++;
            $error("data request changed before acceptance");
        end

    inst_ok_expected: assert property (@(posedge clk) disable iff (!arst_n)
        inst_data_ok |-> inst_pending)
        else begin
            fail_count++;
            $error("inst_data_ok without an accepted request");
        end

    data_ok_expected: assert property (@(posedge clk) disable iff (!arst_n)
        data_data_ok |-> data_pending)
        else begin
            fail_count++;
            $error("data_data_ok without an accepted request");
        end

    // one writeback pulse per instruction
    wb_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (debug_wb_rf_wen != '0) |=> (debug_wb_rf_wen == '0))
        else begin
            fail_count++;
            $error("writeback enable held for more than one cycle");
        end

endmodule

bind mycpu mycpu_assert u_mycpu_assert (.*);

/* testbench/tb_mycpu.sv */
`timescale 1ns/1ns

module tb_mycpu;
    import mips_pkg::*;

    typedef struct packed {
        word_t      pc;
        creg_addr_t num;
        word_t      val;
    } wb_t;

    logic clk = 1'b0;
    logic arst_n;
    logic inst_req, inst_addr_ok, inst_data_ok;
    word_t inst_addr, inst_rdata;
    logic data_req, data_wr, data_addr_ok, data_data_ok;
    logic [1:0] data_size;
    word_t data_addr, data_wdata, data_rdata;
    word_t debug_wb_pc, debug_wb_rf_wdata;
    rwen_t debug_wb_rf_wen;
    creg_addr_t debug_wb_rf_wnum;

    word_t mem [1024];
    wb_t   exp_q [$];
    int    errors = 0;
    int    tests = 0;
    int    stores = 0;
    logic  first_fetch = 1'b1;

    mycpu DUT (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string name, input word_t exp, input word_t act);
        tests++;
        assert (exp == act) begin
            $display("ok     %s = %h", name, act);
        end else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // program image, word i at virtual bfc00000 + 4*i
    task automatic load_program();
        word_t prog [23];
        prog = '{32'h3C011234, 32'h34215678, 32'h2402FFFD, 32'h00221821, 32'h00222023,
                 32'h00222824, 32'h00223025, 32'h0041382A, 32'h24000005, 32'h3C08A000,
                 32'hAD010100, 32'h24090085, 32'hA1090101, 32'h8D0A0100, 32'h810B0101,
                 32'h114A0001, 32'h240C0001, 32'h14210001, 32'h240D0007, 32'h0BF00015,
                 32'h240E0009, 32'h240F002A, 32'h0BF00016};
        // unused words hold an address hash
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'(i) * 32'h9e3779b1;
        end
        for (int i = 0; i < 23; i++) begin
            mem[i] = prog[i];
        end
    endtask

    task automatic add_exp(input int idx, input int num, input word_t val);
        exp_q.push_back('{32'hbfc00000 + 32'(idx * 4), 5'(num), val});
    endtask

    task automatic build_expected();
        word_t r1, r2, r10;
        r1 = (32'h1234 << 16) | 32'h5678;
        r2 = 32'd0 + 32'hFFFFFFFD;
        // sb overwrites byte 1 of the stored word
        r10 = (r1 & 32'hFFFF00FF) | (32'h85 << 8);
        add_exp(0, 1, 32'h1234 << 16);
        add_exp(1, 1, r1);
        add_exp(2, 2, r2);
        add_exp(3, 3, r1 + r2);
        add_exp(4, 4, r1 - r2);
        add_exp(5, 5, r1 & r2);
        add_exp(6, 6, r1 | r2);
        add_exp(7, 7, ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0);
        add_exp(9, 8, 32'ha000 << 16);
        add_exp(11, 9, 32'h85);
        add_exp(13, 10, r10);
        add_exp(14, 11, {{24{r10[15]}}, r10[15:8]});
        add_exp(18, 13, 32'd7);
        add_exp(21, 15, 32'h2a);
    endtask

    // instruction port model
    initial begin
        int n;
        int wait_cnt;
        word_t addr;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata = '0;
        forever begin
            wait_cnt = 0;
            while (!inst_req) begin
                @(posedge clk);
                #1;
                wait_cnt++;
                if (wait_cnt > 2000) begin
                    $display("timeout waiting for an instruction request");
                    $display("TEST FAIL");
                    $finish;
                end
            end
            n = $urandom % 4;
            repeat (n) @(posedge clk);
            #1;
            addr = inst_addr;
            if (first_fetch) begin
                first_fetch = 1'b0;
                check_value("first fetch address", 32'h1fc00000, addr);
            end
            inst_addr_ok = 1'b1;
            @(posedge clk);
            #1;
            inst_addr_ok = 1'b0;
            n = $urandom % 4;
            repeat (n) @(posedge clk);
            #(n > 0 ? 1 : 0);
            inst_rdata = mem[addr[11:2]];
            inst_data_ok = 1'b1;
            @(posedge clk);
            #1;
            inst_data_ok = 1'b0;
        end
    end

    // data port model
    initial begin
        int n;
        int wait_cnt;
        word_t addr, wd;
        logic wr;
        logic [1:0] size;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        data_rdata = '0;
        forever begin
            wait_cnt = 0;
            while (!data_req) begin
                @(posedge clk);
                #1;
                wait_cnt++;
                if (wait_cnt > 2000) begin
                    $display("timeout waiting for a data request");
                    $display("TEST FAIL");
                    $finish;
                end
            end
            n = $urandom % 4;
            repeat (n) @(posedge clk);
            #1;
            addr = data_addr;
            wr = data_wr;
            size = data_size;
            wd = data_wdata;
            if (wr) begin
                stores++;
                check_value("store addr top bits", 32'h0, {29'h0, addr[31:29]});
                check_value("store size", (stores == 1) ? 32'd2 : 32'd0, {30'h0, size});
            end
            data_addr_ok = 1'b1;
            @(posedge clk);
            #1;
            data_addr_ok = 1'b0;
            n = $urandom % 4;
            repeat (n) @(posedge clk);
            #(n > 0 ? 1 : 0);
            if (wr && size == 2'd2) begin
                mem[addr[11:2]] = wd;
            end else if (wr) begin
                mem[addr[11:2]][{addr[1:0], 3'b000} +: 8] = wd[{addr[1:0], 3'b000} +: 8];
            end
            data_rdata = mem[addr[11:2]];
            data_data_ok = 1'b1;
            @(posedge clk);
            #1;
            data_data_ok = 1'b0;
        end
    end

    // writeback monitor, in program order
    always @(posedge clk) begin
        wb_t e;
        if (arst_n && debug_wb_rf_wen != '0) begin
            if (exp_q.size() == 0) begin
                $display("unexpected writeback to r%0d at pc %h", debug_wb_rf_wnum, debug_wb_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_value($sformatf("wb pc r%0d", e.num), e.pc, debug_wb_pc);
                check_value($sformatf("wb num r%0d", e.num), 32'(e.num), 32'(debug_wb_rf_wnum));
                check_value($sformatf("wb val r%0d", e.num), e.val, debug_wb_rf_wdata);
            end
        end
    end

    initial begin
        int wait_cnt;
        void'($urandom(48322));
        arst_n = 1'b0;
        load_program();
        build_expected();
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait_cnt = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 3000) begin
                $display("timeout, %0d writebacks never arrived", exp_q.size());
                $display("TEST FAIL");
                $finish;
            end
        end
        // skipped instructions must stay silent while the loop spins
        repeat (40) @(posedge clk);
        check_value("store count", 32'd2, 32'(stores));
        errors += DUT.u_mycpu_assert.fail_count;
        $display("%0d checks, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/mips_pkg.sv
src/alu.sv
src/regfile.sv
src/decoder.sv
src/datapath.sv
src/mycpu.sv
testbench/mycpu_assert.sv
testbench/tb_mycpu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Isrc -f all.f --top-module tb_mycpu -o sim_mycpu &&
./obj_dir/sim_mycpu | tee /dev/stderr | grep -q "TEST PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
